/* vlog.f */
+incdir+rtl
rtl/decodePkg.sv
rtl/decodeIf.sv
rtl/instrDecoder.sv
rtl/regFileWb.sv
rtl/operandStage.sv
rtl/idecodeTop.sv
verif/idecode_chk.sv
verif/idecodeTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= idecodeTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/decode_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/idecodeTb.sv */
`include "decode_params.svh"

module idecodeTb
    import decodePkg::*;
();
    logic               clock = 1'b0;
    logic               arstN;
    logic [`DATA_W-1:0] instruction, pcPlus4, wbData, aluResult;
    logic               memToReg, jal, jalr, bgezal, bltzal, negative, regWrite;
    logic [`REG_AW-1:0] waddr;
    logic [25:0]        jumpPc;
    logic [`DATA_W-1:0] readData1, readData2, writeData, extImm;
    logic [`REG_AW-1:0] writeAddrR, writeAddrI, rs;
    opKindT             opKind;
    logic [`DATA_W-1:0] model [`REG_CNT];  // expected register file
    int                 cycles = 0;

    idecodeTop idecodeTop_i (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) abortRun("timeout, tests did not finish within 2000 cycles");
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic checkWord(input string name, input logic [`DATA_W-1:0] got, exp);
        if (got !== exp) abortRun($sformatf("Mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkAddr(input string name, input logic [`REG_AW-1:0] got, exp);
        if (got !== exp) abortRun($sformatf("Mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic checkKind(input string name, input opKindT got, exp);
        if (got !== exp) abortRun($sformatf("Mismatch %s got %h expected %h", name, got, exp));
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic opKindT expKind(input logic [5:0] op);
        if (op == 0) return opRType;
        if (op == 1) return opRegImm;
        if (op == 2) return opJump;
        if (op == 3) return opJal;
        if (op >= 4 && op <= 7) return opBranch;
        if (op >= 8 && op <= 11) return opArithImm;
        if (op >= 12 && op <= 14) return opLogicImm;
        if (op == 15) return opLui;
        if (op >= 32 && op <= 37) return opLoad;
        if (op >= 40 && op <= 43) return opStore;
        return opOther;
    endfunction

    function automatic logic [`DATA_W-1:0] rType(input logic [4:0] a, b);
        return {6'd0, a, b, 5'd3, 11'd0};
    endfunction

    task automatic checkDecode(input logic [`DATA_W-1:0] ins, expA, expB);
        logic [`DATA_W-1:0] imm;
        imm = {{16{ins[15]}}, ins[15:0]};
        if (expKind(ins[31:26]) == opLogicImm) imm = {16'd0, ins[15:0]};  // unsigned
        checkWord("readData1", readData1, expA);
        checkWord("readData2", readData2, expB);
        checkWord("extImm", extImm, imm);
        checkWord("jumpPc", {6'd0, jumpPc}, {6'd0, ins[25:0]});
        checkAddr("rs", rs, ins[25:21]);
        checkAddr("writeAddrI", writeAddrI, ins[20:16]);
        checkAddr("writeAddrR", writeAddrR, ins[15:11]);
        checkKind("opKind", opKind, expKind(ins[31:26]));
    endtask

    // drives one instruction and checks it after the output edge
    task automatic decodeInstr(input logic [`DATA_W-1:0] ins);
        @(posedge clock);
        instruction <= ins;
        @(posedge clock);
        @(negedge clock);
        checkDecode(ins, model[ins[25:21]], model[ins[20:16]]);
    endtask

    // flags packed as {jal, jalr, bgezal, bltzal}
    task automatic writeBack(input logic [3:0] flags, input logic wr, mem, neg,
                             input logic [`REG_AW-1:0] addr);
        logic [`DATA_W-1:0] pc, md, ad, exp;
        logic               lnk;
        logic [`REG_AW-1:0] dest;
        pc = $urandom;
        md = $urandom;
        ad = $urandom;
        lnk = flags[3] | flags[2] | (flags[1] & ~neg) | (flags[0] & neg);
        exp = lnk ? pc : (mem ? md : ad);
        dest = (flags[3] || flags[1] || flags[0]) ? 5'd`LINK_REG : addr;
        @(posedge clock);
        {jal, jalr, bgezal, bltzal} <= flags;
        {regWrite, memToReg, negative, waddr} <= {wr, mem, neg, addr};
        {pcPlus4, wbData, aluResult} <= {pc, md, ad};
        @(negedge clock);
        checkWord("writeData", writeData, exp);
        @(posedge clock);
        {jal, jalr, bgezal, bltzal, regWrite} <= '0;
        if ((wr || lnk) && dest != 0) model[dest] = exp;
    endtask

    task automatic sameCycle(input logic [`REG_AW-1:0] r);
        logic [`DATA_W-1:0] ins, d, old;
        ins = rType(r, r);
        d = $urandom;
        old = model[r];
        @(posedge clock);
        instruction <= ins;
        {regWrite, memToReg, waddr, aluResult} <= {1'b1, 1'b0, r, d};
        @(posedge clock);
        regWrite <= 1'b0;
        @(negedge clock);
        checkDecode(ins, old, old);  // no forwarding
        if (r != 0) model[r] = d;
        decodeInstr(ins);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic testReset();
        checkDecode(32'h0000_0000 | {6'd63, 26'd0}, 0, 0);
        for (int i = 0; i < 8; i++) decodeInstr(rType(5'($urandom), 5'($urandom)));
    endtask

    task automatic testWrites();
        for (int i = 0; i < 20; i++) writeBack(4'b0000, 1'b1, 1'($urandom), 1'b0, 5'($urandom));
        writeBack(4'b0000, 1'b1, 1'b0, 1'b0, 5'd0);
        for (int i = 0; i < 12; i++) decodeInstr(rType(5'($urandom), 5'($urandom)));
        decodeInstr(rType(5'd0, 5'd0));
    endtask

    task automatic testLinks();
        writeBack(4'b1000, 1'b0, 1'b0, 1'b0, 5'd7);
        decodeInstr(rType(5'd31, 5'd7));
        writeBack(4'b0100, 1'b0, 1'b0, 1'b0, 5'd9);
        decodeInstr(rType(5'd9, 5'd31));
        for (int n = 0; n < 2; n++) begin
            writeBack(4'b0010, 1'b0, 1'b0, n[0], 5'd4);
            decodeInstr(rType(5'd31, 5'd4));
            writeBack(4'b0001, 1'b0, 1'b0, n[0], 5'd4);
            decodeInstr(rType(5'd31, 5'd4));
        end
    endtask

    task automatic testFields();
        logic [5:0] ops [13] = '{0, 1, 2, 3, 4, 8, 12, 13, 14, 15, 32, 40, 63};
        logic [31:0] ins;
        for (int i = 0; i < 100; i++) begin
            ins = $urandom;
            if (i < 13) begin
                ins[31:26] = ops[i];  // every class at least once
                ins[15]    = 1'b1;    // negative imm tells zero from sign extension
            end
            decodeInstr(ins);
        end
    endtask

    initial begin
        void'($urandom(8253));
        arstN = 1'b0;
        {instruction, pcPlus4, wbData, aluResult, waddr} = '0;
        {memToReg, jal, jalr, bgezal, bltzal, negative, regWrite} = '0;
        foreach (model[i]) model[i] = '0;
        repeat (2) @(posedge clock);
        arstN <= 1'b1;
        @(negedge clock);
        testReset();
        testWrites();
        testLinks();
        testFields();
        sameCycle(5'd12);
        sameCycle(5'd0);
        sameCycle(5'd31);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* verif/idecode_chk.sv */
`include "decode_params.svh"

module idecodeChk
    import decodePkg::*;
(
    input logic               clock,
    input logic               arstN,
    input logic               jal,
    input logic [`DATA_W-1:0] pcPlus4,
    input logic [`DATA_W-1:0] writeData,
    input logic [`DATA_W-1:0] readData1,
    input logic [`DATA_W-1:0] readData2,
    input logic [`DATA_W-1:0] extImm,
    input logic [25:0]        jumpPc,
    input logic [`REG_AW-1:0] writeAddrR,
    input logic [`REG_AW-1:0] writeAddrI,
    input logic [`REG_AW-1:0] rs,
    input opKindT             opKind,
    input logic [`DATA_W-1:0] regZero
);

    ////////////////////
    // reset behavior
    ////////////////////

    // outputs have seen at least one reset edge by the next sample
    assert property (@(posedge clock) !arstN |=> (readData1 == '0 && readData2 == '0 &&
        extImm == '0 && jumpPc == '0 && writeAddrR == '0 && writeAddrI == '0 &&
        rs == '0 && opKind == opOther))
        else $error("output register not cleared during reset");

    assert property (@(posedge clock) $rose(arstN) |=> !$isunknown(opKind))
        else $error("opKind unknown after reset");

    // $0 is hardwired
    assert property (@(posedge clock) disable iff (!arstN) regZero == '0)
        else $error("register 0 was written");

    assert property (@(posedge clock) disable iff (!arstN) jal |-> writeData == pcPlus4)
        else $error("jal write data is not pcPlus4");

endmodule

bind idecodeTop idecodeChk idecodeChk_i (
    .clock      (clock),
    .arstN      (arstN),
    .jal        (jal),
    .pcPlus4    (pcPlus4),
    .writeData  (writeData),
    .readData1  (readData1),
    .readData2  (readData2),
    .extImm     (extImm),
    .jumpPc     (jumpPc),
    .writeAddrR (writeAddrR),
    .writeAddrI (writeAddrI),
    .rs         (rs),
    .opKind     (opKind),
    .regZero    (regFileWb_i.regs[0])
);

/* rtl/idecodeTop.sv */
`include "decode_params.svh"

module idecodeTop
    import decodePkg::*;
(
    input  logic               clock,
    input  logic               arstN,
    // instruction being decoded
    input  logic [`DATA_W-1:0] instruction,
    // write-back from an older instruction
    input  logic [`DATA_W-1:0] pcPlus4,
    input  logic [`DATA_W-1:0] wbData,
    input  logic [`DATA_W-1:0] aluResult,
    input  logic               memToReg,
    input  logic [`REG_AW-1:0] waddr,
    input  logic               jal,
    input  logic               jalr,
    input  logic               bgezal,
    input  logic               bltzal,
    input  logic               negative,
    input  logic               regWrite,
    // to EX, one cycle after decode
    output logic [25:0]        jumpPc,
    output logic [`DATA_W-1:0] readData1,
    output logic [`DATA_W-1:0] readData2,
    output logic [`REG_AW-1:0] writeAddrR,
    output logic [`REG_AW-1:0] writeAddrI,
    output logic [`DATA_W-1:0] writeData,  // combinational
    output logic [`DATA_W-1:0] extImm,
    output logic [`REG_AW-1:0] rs,
    output opKindT             opKind
);

    logic [`DATA_W-1:0] readA;
    logic [`DATA_W-1:0] readB;

    decodeIf fields ();

    instrDecoder instrDecoder_i (
        .instruction (instruction),
        .fields      (fields)
    );

    regFileWb regFileWb_i (
        .clock     (clock),
        .arstN     (arstN),
        .fields    (fields),
        .pcPlus4   (pcPlus4),
        .wbData    (wbData),
        .aluResult (aluResult),
        .memToReg  (memToReg),
        .waddr     (waddr),
        .jal       (jal),
        .jalr      (jalr),
        .bgezal    (bgezal),
        .bltzal    (bltzal),
        .negative  (negative),
        .regWrite  (regWrite),
        .readA     (readA),
        .readB     (readB),
        .writeData (writeData)
    );

    operandStage operandStage_i (
        .clock      (clock),
        .arstN      (arstN),
        .fields     (fields),
        .readA      (readA),
        .readB      (readB),
        .jumpPc     (jumpPc),
        .readData1  (readData1),
        .readData2  (readData2),
        .extImm     (extImm),
        .writeAddrR (writeAddrR),
        .writeAddrI (writeAddrI),
        .rs         (rs),
        .opKind     (opKind)
    );

endmodule

/* rtl/operandStage.sv */
`include "decode_params.svh"

module operandStage
    import decodePkg::*;
(
    input  logic               clock,
    input  logic               arstN,
    decodeIf.dst               fields,
    input  logic [`DATA_W-1:0] readA,
    input  logic [`DATA_W-1:0] readB,
    output logic [25:0]        jumpPc,
    output logic [`DATA_W-1:0] readData1,
    output logic [`DATA_W-1:0] readData2,
    output logic [`DATA_W-1:0] extImm,
    output logic [`REG_AW-1:0] writeAddrR,  // rd, R-type destination
    output logic [`REG_AW-1:0] writeAddrI,  // rt, I-type destination
    output logic [`REG_AW-1:0] rs,
    output opKindT             opKind
);

    logic [`DATA_W-1:0] immNext;

    ////////////////////
    // immediate extend
    ////////////////////

    // logical immediates are unsigned, everything else sign extends
    always_comb begin
        if (fields.kind == opLogicImm) begin
            immNext = {{(`DATA_W-16){1'b0}}, fields.imm};
        end else begin
            immNext = {{(`DATA_W-16){fields.imm[15]}}, fields.imm};
        end
    end

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            jumpPc     <= '0;
            readData1  <= '0;
            readData2  <= '0;
            extImm     <= '0;
            writeAddrR <= '0;
            writeAddrI <= '0;
            rs         <= '0;
            opKind     <= opOther;
        end else begin
            jumpPc     <= fields.target;
            readData1  <= readA;
            readData2  <= readB;
            extImm     <= immNext;
            writeAddrR <= fields.rd;
            writeAddrI <= fields.rt;
            rs         <= fields.rs;
            opKind     <= fields.kind;
        end
    end

endmodule

/* rtl/regFileWb.sv */
`include "decode_params.svh"

module regFileWb
    import decodePkg::*;
(
    input  logic               clock,
    input  logic               arstN,
    decodeIf.dst               fields,
    input  logic [`DATA_W-1:0] pcPlus4,
    input  logic [`DATA_W-1:0] wbData,     // load data
    input  logic [`DATA_W-1:0] aluResult,
    input  logic               memToReg,
    input  logic [`REG_AW-1:0] waddr,
    input  logic               jal,
    input  logic               jalr,
    input  logic               bgezal,
    input  logic               bltzal,
    input  logic               negative,   // sign of rs for the linking branches
    input  logic               regWrite,
    output logic [`DATA_W-1:0] readA,
    output logic [`DATA_W-1:0] readB,
    output logic [`DATA_W-1:0] writeData
);

    logic [`DATA_W-1:0] regs [`REG_CNT];
    logic               linkBr;   // branch-and-link taken
    logic               link;
    wbSrcT              wbSrc;
    logic [`REG_AW-1:0] wrAddr;
    logic               wrEn;

    ////////////////////
    // write-back select
    ////////////////////

    assign linkBr = (bgezal & ~negative) | (bltzal & negative);
    assign link   = jal | jalr | linkBr;
    assign wbSrc  = link ? wsLink : (memToReg ? wsMem : wsAlu);
    assign wrEn   = regWrite | link;

    always_comb begin
        if (jal || (!jalr && linkBr)) begin
            wrAddr = `REG_AW'(`LINK_REG);
        end else begin
            wrAddr = waddr;  // jalr names its own link register
        end
    end

    always_comb begin
        case (wbSrc)
            wsLink:  writeData = pcPlus4;
            wsMem:   writeData = wbData;
            default: writeData = aluResult;
        endcase
    end

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin  // $0 stays zero
            regs[wrAddr] <= writeData;
        end
    end

    // no bypass, same-edge writes show up next cycle
    assign readA = regs[fields.rs];
    assign readB = regs[fields.rt];

endmodule

/* rtl/instrDecoder.sv */
`include "decode_params.svh"

module instrDecoder
    import decodePkg::*;
(
    input  logic [`DATA_W-1:0] instruction,
    decodeIf.src               fields
);

    logic [5:0] opcode;

    assign opcode = instruction[31:26];

    ////////////////////
    // field split
    ////////////////////

    assign fields.rs     = instruction[25:21];
    assign fields.rt     = instruction[20:16];
    assign fields.rd     = instruction[15:11];
    assign fields.imm    = instruction[15:0];
    assign fields.target = instruction[25:0];

    ////////////////////
    // opcode class
    ////////////////////

    always_comb begin
        case (opcode)
            6'd0: begin
                fields.kind = opRType;
            end
            6'd1: begin
                fields.kind = opRegImm;  // rt picks the variant
            end
            6'd2: begin
                fields.kind = opJump;
            end
            6'd3: begin
                fields.kind = opJal;
            end
            6'd4, 6'd5, 6'd6, 6'd7: begin
                fields.kind = opBranch;
            end
            6'd8, 6'd9, 6'd10, 6'd11: begin
                fields.kind = opArithImm;
            end
            6'd12, 6'd13, 6'd14: begin
                fields.kind = opLogicImm;
            end
            6'd15: begin
                fields.kind = opLui;
            end
            6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37: begin
                fields.kind = opLoad;    // lb .. lhu, lwl
            end
            6'd40, 6'd41, 6'd42, 6'd43: begin
                fields.kind = opStore;
            end
            default: begin
                fields.kind = opOther;
            end
        endcase
    end

endmodule

/* rtl/decodeIf.sv */
`include "decode_params.svh"

// decoded fields of the instruction currently in ID
interface decodeIf
    import decodePkg::*;
();
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [15:0]        imm;
    logic [25:0]        target;  // j/jal word target
    opKindT             kind;

    // decoder side
    modport src (
        output rs, rt, rd, imm, target, kind
    );

    // register file and operand register side
    modport dst (
        input  rs, rt, rd, imm, target, kind
    );

endinterface

/* rtl/decodePkg.sv */
package decodePkg;

    ////////////////////
    // opcode classes
    ////////////////////

    // primary opcode field, instruction[31:26]
    typedef enum logic [3:0] {
        opRType    = 4'h0,  // special, funct decides
        opRegImm   = 4'h1,  // bltz/bgez and the linking forms
        opJump     = 4'h2,
        opJal      = 4'h3,
        opBranch   = 4'h4,  // beq, bne, blez, bgtz
        opArithImm = 4'h5,  // addi .. sltiu
        opLogicImm = 4'h6,  // andi, ori, xori
        opLui      = 4'h7,
        opLoad     = 4'h8,
        opStore    = 4'h9,
        opOther    = 4'hf
    } opKindT;

    ////////////////////
    // write-back mux
    ////////////////////

    typedef enum logic [1:0] {
        wsAlu  = 2'd0,
        wsMem  = 2'd1,
        wsLink = 2'd2   // return address
    } wbSrcT;

endpackage

/* rtl/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath and register file sizing
`define DATA_W   32
`define REG_CNT  32
`define REG_AW   5

// return address register for jal and linking branches
`define LINK_REG 31

`endif
